//--- verif/cds_inject_testdata.txt
# op idx value expected, decimal; value is a level, a step count or a step bound
# expect idx 0 key_pressed 1 inject_pulse 2 reset_req_n 3 heartbeat_led; measure idx 0-1 inject 2-4 req
expect 0 0 0
expect 1 0 0
expect 2 0 7
expect 3 0 0
beat 4 110 25
glitch 0 6 0
set_key 0 0 0
wait 0 18 0
expect 0 0 0
wait 0 3 0
expect 0 0 1
glitch 0 4 1
set_key 0 1 0
wait 0 21 0
expect 0 0 0
glitch 1 5 0
set_inject 0 1 0
wait 0 4 0
expect 1 0 0
wait 0 1 0
expect 1 0 1
wait 0 15 0
set_inject 0 0 0
wait 0 2 0
set_inject 0 1 0
wait 0 22 0
expect 1 0 1
wait 0 1 0
expect 1 0 0
set_inject 1 1 0
measure 1 60 40
set_req 0 1 0
measure 2 20 6
set_req 1 1 0
measure 3 20 2
set_req 2 1 0
measure 4 50 32
set_req 2 0 0
wait 0 3 0
set_req 2 1 0
wait 0 5 0
expect 2 0 3
wait 0 5 0
set_req 2 0 0
wait 0 2 0
set_req 2 1 0
wait 0 24 0
expect 2 0 3
wait 0 1 0
expect 2 0 7

//--- cds_inject_top.f
common/cds_pkg.sv
logic/key_debounce.sv
logic/reset_pulse_gen.sv
inject/inject_receiver.sv
logic/heartbeat.sv
logic/cds_inject_top.sv
verif/cds_inject_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the cds inject testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f cds_inject_top.f \
      --top-module cds_inject_tb -o cds_inject_sim; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/cds_inject_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
   exit 0
fi
exit 1

//--- verif/cds_inject_tb.sv
// cds inject testbench that replays the step file and checks every top level output

`default_nettype none

module cds_inject_tb
   import cds_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned DEB_CYCLES   = 16;
   localparam int unsigned PULSE_CYCLES = 40;
   localparam int unsigned HB_HALF      = 25;
   localparam int unsigned DRIVE_DELAY  = 10;                            // ns after rising edge
   localparam int unsigned SETTLE       = SYNC_STAGES + DEB_CYCLES + 2;  // key settle steps
   localparam int unsigned EDGE_DELAY   = SYNC_STAGES + 2;  // drive step to first active step
   localparam string       STEP_FILE    = "verif/cds_inject_testdata.txt";

   logic       fpga_clk_50;
   logic       hps_fpga_reset_n;
   key_t       key;
   inject_t    inject_in;
   reset_req_t reset_req;
   key_t       key_pressed;
   inject_t    inject_pulse;
   reset_req_t reset_req_n;
   logic       heartbeat_led;

   int unsigned rel_cycle;          // steps since reset release
   int unsigned watch_cycles = 0;   // clocks since time zero
   int unsigned cycle_limit  = 0;   // zero until the step file is sized
   logic [31:0] rng_state;          // glitch length source

   cds_inject_top #(
      .DEBOUNCE_CYCLES     (DEB_CYCLES),
      .INJECT_PULSE_CYCLES (PULSE_CYCLES),
      .HEARTBEAT_HALF      (HB_HALF)
   ) cds_inject_top_i (.*);

   initial
   begin
      fpga_clk_50 = 1'b0;
      forever #50 fpga_clk_50 = ~fpga_clk_50;   // 100 ns period
   end

   always @(posedge fpga_clk_50)
   begin
      watch_cycles <= watch_cycles + 1;
      if (cycle_limit != 0 && watch_cycles >= cycle_limit)
         abort_run("the run timed out before all test steps finished");
   end

   // ======================================================================
   // helpers
   // ======================================================================
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic abort_run(input string reason);
      $display("%s (time %0t)", reason, $time);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("Error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic next_cycle();
      @(posedge fpga_clk_50);
      #DRIVE_DELAY;            // drive and sample point
      rel_cycle++;
   endtask

   function automatic logic [31:0] output_value(input int sel);
      case (sel)
         0:       return 32'(key_pressed);
         1:       return 32'(inject_pulse);
         2:       return 32'(reset_req_n);
         default: return 32'(heartbeat_led);
      endcase
   endfunction

   // bits 0-1 inject pulses, 2-4 reset requests, all active high
   function automatic logic [4:0] active_lines();
      return {~reset_req_n, inject_pulse};
   endfunction

   // ======================================================================
   // step operations
   // ======================================================================
   task automatic measure_pulse(input int line, input int bound, input int length);
      logic [4:0]  act;
      int unsigned delay;
      int unsigned width;
      delay = 0;
      width = 0;
      do
      begin
         next_cycle();
         delay++;
         act = active_lines();
      end while (!act[line] && delay < bound);
      if (!act[line])
         abort_run("no pulse started on the measured line");
      check_value("pulse start delay", delay, EDGE_DELAY);
      while (act[line] && delay + width < bound)
      begin
         check_value("other output lines", 32'(act & ~(5'b1 << line)), 0);  // must stay idle
         width++;
         next_cycle();
         act = active_lines();
      end
      if (act[line])
         abort_run("the measured pulse did not end within its bound");
      check_value("pulse length", width, length);
   endtask

   task automatic hold_key(input int k, input int steps, input int held);
      repeat (steps)
      begin
         next_cycle();
         check_value("key_pressed bit", 32'(key_pressed[k]), held);
      end
   endtask

   task automatic key_glitches(input int k, input int count, input int held);
      int unsigned len;
      for (int g = 0; g < count; g++)
      begin
         rng_state = xorshift(rng_state);
         len = rng_state % (DEB_CYCLES - 1) + 1;   // 1 .. DEB_CYCLES-1
         key[k] = ~key[k];
         hold_key(k, len, held);
         key[k] = ~key[k];                        // back to rest for a short gap
         hold_key(k, 2, held);
      end
      hold_key(k, SETTLE, held);                  // still unchanged after settling
   endtask

   task automatic watch_heartbeat(input int toggles, input int bound, input int half);
      logic        last_led;
      int unsigned seen;
      seen = 0;
      last_led = heartbeat_led;
      for (int n = 0; n < bound && seen < toggles; n++)
      begin
         next_cycle();
         if (heartbeat_led !== last_led)
         begin
            seen++;
            check_value("heartbeat toggle step", rel_cycle, seen * half);
            last_led = heartbeat_led;
         end
      end
      if (seen < toggles)
         abort_run("the heartbeat LED stopped toggling");
   endtask

   task automatic run_step(input string op, input int idx, input int val, input int expected);
      if (op == "set_key")
         key[idx] = val[0];
      else if (op == "set_inject")
         inject_in[idx] = val[0];
      else if (op == "set_req")
         reset_req[idx] = val[0];
      else if (op == "wait")
         repeat (val) next_cycle();
      else if (op == "expect")
         check_value($sformatf("output %0d", idx), output_value(idx), expected);
      else if (op == "measure")
         measure_pulse(idx, val, expected);
      else if (op == "glitch")
         key_glitches(idx, val, expected);
      else if (op == "beat")
         watch_heartbeat(idx, val, expected);
      else
         abort_run({"unknown operation in the step file: ", op});
   endtask

   task automatic read_step(input int fd, output string op, output int idx, output int val,
                            output int expected, output bit got);
      int    n;
      string rest;
      got = 1'b0;
      n = $fscanf(fd, "%s", op);
      while (n == 1 && op.substr(0, 0) == "#")    // comment line
      begin
         n = $fgets(rest, fd);
         n = $fscanf(fd, "%s", op);
      end
      if (n == 1)
      begin
         n = $fscanf(fd, "%d %d %d", idx, val, expected);
         if (n != 3)
            abort_run({"a step line has too few fields after ", op});
         got = 1'b1;
      end
   endtask

   // ======================================================================
   // main sequence
   // ======================================================================
   initial
   begin
      int          fd;
      string       op;
      int          idx;
      int          val;
      int          expected;
      bit          got;
      int unsigned limit;
      key              = '1;     // keys released
      inject_in        = '0;
      reset_req        = '0;
      hps_fpga_reset_n = 1'b0;
      rel_cycle        = 0;
      rng_state        = 32'h130b;

      // first pass sizes the timeout
      fd = $fopen(STEP_FILE, "r");
      if (fd == 0)
         abort_run("could not open the step file");
      limit = 500;
      read_step(fd, op, idx, val, expected, got);
      while (got)
      begin
         if (op == "wait" || op == "measure" || op == "beat")
            limit += val;
         else if (op == "glitch")
            limit += val * (DEB_CYCLES + 2) + SETTLE;
         read_step(fd, op, idx, val, expected, got);
      end
      $fclose(fd);
      cycle_limit = limit;

      repeat (10) @(posedge fpga_clk_50);
      #DRIVE_DELAY;
      hps_fpga_reset_n = 1'b1;   // step zero

      fd = $fopen(STEP_FILE, "r");
      read_step(fd, op, idx, val, expected, got);
      while (got)
      begin
         run_step(op, idx, val, expected);
         read_step(fd, op, idx, val, expected, got);
      end
      $fclose(fd);

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/cds_inject_top.sv
// cds inject top: keys, inject receivers, reset request pulses and heartbeat

`default_nettype none

module cds_inject_top
   import cds_pkg::*;
#(
   parameter int unsigned DEBOUNCE_CYCLES     = DEF_DEBOUNCE_CYCLES,
   parameter int unsigned INJECT_PULSE_CYCLES = DEF_INJECT_PULSE_CYCLES,
   parameter int unsigned HEARTBEAT_HALF      = DEF_HEARTBEAT_HALF
)
(
   input  wire logic       fpga_clk_50,
   input  wire logic       hps_fpga_reset_n,
   input  wire key_t       key,            // push keys, active low
   input  wire inject_t    inject_in,      // external inject lines
   input  wire reset_req_t reset_req,      // cold, warm, debug request levels
   output key_t            key_pressed,
   output inject_t         inject_pulse,
   output reset_req_t      reset_req_n,    // active low toward the hps
   output logic            heartbeat_led
);

   // ======================================================================
   // push keys
   // ======================================================================
   key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) key_debounce_i
   (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .key              (key),
      .key_pressed      (key_pressed)
   );

   // ======================================================================
   // inject channels
   // ======================================================================
   for (genvar ch = 0; ch < NUM_INJECT; ch++)
   begin : g_inject
      inject_receiver #(.INJECT_PULSE_CYCLES(INJECT_PULSE_CYCLES)) inject_receiver_i
      (
         .fpga_clk_50      (fpga_clk_50),
         .hps_fpga_reset_n (hps_fpga_reset_n),
         .inject_in        (inject_in[ch]),
         .inject_pulse     (inject_pulse[ch])
      );
   end

   // ======================================================================
   // hps reset requests, one width each
   // ======================================================================
   reset_pulse_gen #(.PULSE_CYCLES(COLD_PULSE_CYCLES)) cold_reset_i
   (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .req              (reset_req[0]),
      .pulse_n          (reset_req_n[0])
   );

   reset_pulse_gen #(.PULSE_CYCLES(WARM_PULSE_CYCLES)) warm_reset_i
   (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .req              (reset_req[1]),
      .pulse_n          (reset_req_n[1])
   );

   reset_pulse_gen #(.PULSE_CYCLES(DEBUG_PULSE_CYCLES)) debug_reset_i
   (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .req              (reset_req[2]),
      .pulse_n          (reset_req_n[2])
   );

   // board alive indicator
   heartbeat #(.HEARTBEAT_HALF(HEARTBEAT_HALF)) heartbeat_i
   (
      .fpga_clk_50      (fpga_clk_50),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .heartbeat_led    (heartbeat_led)
   );

endmodule

`default_nettype wire

//--- logic/heartbeat.sv
// heartbeat led: toggles a level every half period to show the fabric clock runs

`default_nettype none

module heartbeat
   import cds_pkg::*;
#(
   parameter int unsigned HEARTBEAT_HALF = DEF_HEARTBEAT_HALF
)
(
   input  wire logic fpga_clk_50,
   input  wire logic hps_fpga_reset_n,
   output logic      heartbeat_led
);

   localparam int unsigned CNT_W = (HEARTBEAT_HALF > 1) ? $clog2(HEARTBEAT_HALF) : 1;

   logic [CNT_W-1:0] half_cnt;   // cycles into current half period

   always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
   begin
      if (!hps_fpga_reset_n)
      begin
         half_cnt      <= '0;
         heartbeat_led <= 1'b0;     // led off out of reset
      end
      else if (half_cnt == CNT_W'(HEARTBEAT_HALF - 1))
      begin
         half_cnt      <= '0;       // wrap
         heartbeat_led <= ~heartbeat_led;
      end
      else
         half_cnt <= half_cnt + 1'b1;
   end

endmodule

`default_nettype wire

//--- inject/inject_receiver.sv
// inject receiver: synchronizes one inject line and stretches its rising edge

`default_nettype none

module inject_receiver
   import cds_pkg::*;
#(
   parameter int unsigned INJECT_PULSE_CYCLES = DEF_INJECT_PULSE_CYCLES
)
(
   input  wire logic fpga_clk_50,
   input  wire logic hps_fpga_reset_n,
   input  wire logic inject_in,      // contact closure from the injector
   output logic      inject_pulse    // event, high for INJECT_PULSE_CYCLES
);

   localparam int unsigned CNT_W =
      (INJECT_PULSE_CYCLES > 1) ? $clog2(INJECT_PULSE_CYCLES) : 1;

   logic [SYNC_STAGES-1:0] in_sync;    // metastability chain
   logic                   in_last;    // synchronized level
   logic                   in_d;       // edge detect flop
   logic                   in_rise;    // one cycle strobe
   stretch_state_e         state;
   logic [CNT_W-1:0]       remain;     // cycles left in pulse minus one

   assign in_last = in_sync[SYNC_STAGES-1];

   // ======================================================================
   // synchronizer and rising edge
   // ======================================================================
   always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
   begin
      if (!hps_fpga_reset_n)
      begin
         in_sync <= '0;
         in_d    <= 1'b0;
         in_rise <= 1'b0;
      end
      else
      begin
         in_sync <= {in_sync[SYNC_STAGES-2:0], inject_in};  // shift in
         in_d    <= in_last;
         in_rise <= in_last & ~in_d;   // low to high only
      end
   end

   // ======================================================================
   // pulse stretcher
   // ======================================================================
   always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
   begin
      if (!hps_fpga_reset_n)
      begin
         state        <= idle;
         remain       <= '0;
         inject_pulse <= 1'b0;
      end
      else
      begin
         unique case (state)
            idle:
            begin
               if (in_rise)
               begin
                  state        <= busy;
                  remain       <= CNT_W'(INJECT_PULSE_CYCLES - 1);
                  inject_pulse <= 1'b1;
               end
            end
            busy:
            begin
               // a second inject while busy neither retriggers nor extends
               if (remain == '0)
               begin
                  state        <= idle;
                  inject_pulse <= 1'b0;
               end
               else
                  remain <= remain - 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/reset_pulse_gen.sv
// reset request pulse generator: request edge to active-low pulse of fixed width

`default_nettype none

module reset_pulse_gen
   import cds_pkg::*;
#(
   parameter int unsigned PULSE_CYCLES = COLD_PULSE_CYCLES
)
(
   input  wire logic fpga_clk_50,
   input  wire logic hps_fpga_reset_n,
   input  wire logic req,       // async request level
   output logic      pulse_n    // low for PULSE_CYCLES
);

   localparam int unsigned CNT_W = (PULSE_CYCLES > 1) ? $clog2(PULSE_CYCLES) : 1;

   logic [SYNC_STAGES-1:0] req_sync;   // bit 0 nearest the pin
   logic                   req_d;      // last stage, delayed once
   logic                   req_rise;   // registered rising edge strobe
   stretch_state_e         state;
   logic [CNT_W-1:0]       cnt;        // remaining low cycles minus one

   always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
   begin
      if (!hps_fpga_reset_n)
      begin
         req_sync <= '0;
         req_d    <= 1'b0;
         req_rise <= 1'b0;
         state    <= idle;
         cnt      <= '0;
         pulse_n  <= 1'b1;                          // no request after reset
      end
      else
      begin
         req_sync <= {req_sync[SYNC_STAGES-2:0], req};
         req_d    <= req_sync[SYNC_STAGES-1];
         req_rise <= req_sync[SYNC_STAGES-1] & ~req_d;

         case (state)
            idle:
               if (req_rise)
               begin
                  state   <= busy;
                  cnt     <= CNT_W'(PULSE_CYCLES - 1);
                  pulse_n <= 1'b0;                  // assert request
               end
            busy:
               if (cnt == '0)
               begin
                  state   <= idle;
                  pulse_n <= 1'b1;
               end
               else
                  cnt <= cnt - 1'b1;                // edges here are dropped
            default:
               state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/key_debounce.sv
// key debouncer: synchronizes the active-low push keys and filters bounce

`default_nettype none

module key_debounce
   import cds_pkg::*;
#(
   parameter int unsigned DEBOUNCE_CYCLES = DEF_DEBOUNCE_CYCLES
)
(
   input  wire logic fpga_clk_50,
   input  wire logic hps_fpga_reset_n,
   input  wire key_t key,           // active low, async
   output key_t      key_pressed    // active high, clean
);

   localparam int unsigned CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

   key_t             key_sync [SYNC_STAGES];   // sync chain, stage 0 first
   key_t             key_level;                 // synchronized, active high
   logic [CNT_W-1:0] stable_cnt [NUM_KEYS];     // cycles spent differing

   // ======================================================================
   // input synchronizer
   // ======================================================================
   always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
   begin
      if (!hps_fpga_reset_n)
      begin
         for (int s = 0; s < SYNC_STAGES; s++)
            key_sync[s] <= '1;                  // keys idle high
      end
      else
      begin
         key_sync[0] <= key;
         for (int s = 1; s < SYNC_STAGES; s++)
            key_sync[s] <= key_sync[s-1];
      end
   end

   assign key_level = ~key_sync[SYNC_STAGES-1];  // polarity flip

   // ======================================================================
   // per-key stable counter
   // ======================================================================
   always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
   begin
      if (!hps_fpga_reset_n)
      begin
         key_pressed <= '0;
         for (int k = 0; k < NUM_KEYS; k++)
            stable_cnt[k] <= '0;
      end
      else
      begin
         for (int k = 0; k < NUM_KEYS; k++)
         begin
            if (key_level[k] == key_pressed[k])
               stable_cnt[k] <= '0;             // bounced back, restart
            else if (stable_cnt[k] == CNT_W'(DEBOUNCE_CYCLES - 1))
            begin
               key_pressed[k] <= key_level[k];  // held long enough
               stable_cnt[k]  <= '0;
            end
            else
               stable_cnt[k] <= stable_cnt[k] + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- common/cds_pkg.sv
// cds shared definitions: port widths, pulse lengths and the stretcher states

`default_nettype none

package cds_pkg;

   // ======================================================================
   // channel counts
   // ======================================================================
   localparam int unsigned NUM_KEYS      = 2;   // push keys on the board
   localparam int unsigned NUM_INJECT    = 2;   // inject input channels
   localparam int unsigned NUM_RESET_REQ = 3;   // 0 cold, 1 warm, 2 debug

   localparam int unsigned SYNC_STAGES   = 3;   // metastability chain depth

   // ======================================================================
   // pulse widths and board timing (50 MHz clock)
   // ======================================================================
   localparam int unsigned COLD_PULSE_CYCLES  = 6;
   localparam int unsigned WARM_PULSE_CYCLES  = 2;
   localparam int unsigned DEBUG_PULSE_CYCLES = 32;

   localparam int unsigned DEF_DEBOUNCE_CYCLES     = 50000;     // 1 ms
   localparam int unsigned DEF_INJECT_PULSE_CYCLES = 25000000;  // 0.5 s event
   localparam int unsigned DEF_HEARTBEAT_HALF      = 25000000;  // 1 Hz blink

   // port vectors
   typedef logic [NUM_KEYS-1:0]      key_t;        // one bit per key
   typedef logic [NUM_INJECT-1:0]    inject_t;     // one bit per inject line
   typedef logic [NUM_RESET_REQ-1:0] reset_req_t;  // one bit per request

   // pulse stretcher fsm
   typedef enum logic
   {
      idle = 1'b0,   // waiting for a rising edge
      busy = 1'b1    // pulse running, edges dropped
   } stretch_state_e;

endpackage

`default_nettype wire
